/* files.f */
logic/mmuPkg.sv
logic/tlbPortIf.sv
logic/memReqIf.sv
logic/tlbArray.sv
logic/accessCheck.sv
logic/mmuTlb.sv
logic/l2WbBridge.sv
logic/mmuTop.sv
tb/tbWbSlave.sv
tb/tbMmuTop.sv

/* logic/accessCheck.sv */
`timescale 1ns/1ps

module accessCheck (
	input  mmuPkg::memOpT op,
	input  mmuPkg::tlbEntryT entry,
	input  logic hit,
	input  logic mmuEnable,
	input  logic userMode,
	input  logic [31:0] addr,
	output mmuPkg::excT exc
);
	import mmuPkg::*;

	logic isAccess;
	logic inBypass;

	assign isAccess = op inside {opLoad, opStore, opFetch};
	assign inBypass = addr[bypassBit];

	// first matching rule wins
	always_comb
	begin
		exc = excNone;
		if (!isAccess || !mmuEnable)
		begin
			exc = excNone; // tlb maintenance and identity mapping never fault
		end
		else if (inBypass)
		begin
			if (userMode)
			begin
				exc = excPrivilege; // bypass region is supervisor only
			end
		end
		else if (!hit)
		begin
			exc = excTlbMiss;
		end
		else if (userMode && !entry.userOk)
		begin
			exc = excPrivilege;
		end
		else if (op == opLoad && !entry.readOk)
		begin
			exc = excNoRead;
		end
		else if (op == opStore && !entry.writeOk)
		begin
			exc = excNoWrite;
		end
		else if (op == opFetch && !entry.execOk)
		begin
			exc = excNoExec;
		end
	end

endmodule

/* logic/l2WbBridge.sv */
`timescale 1ns/1ps

module l2WbBridge (
	input  logic clock,
	input  logic arstN,
	memReqIf.bridge mem,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [31:0] wbAdr,
	output logic [31:0] wbDatW,
	input  logic [31:0] wbDatR,
	input  logic wbAck
);

	logic cycEnd;

	assign cycEnd = wbCyc && wbAck;

	// classic cycle, cyc and stb rise on start and drop on ack
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			mem.done <= 1'b0;
		end
		else
		begin
			mem.done <= cycEnd;   // single pulse per cycle
			if (mem.start)
			begin
				wbCyc <= 1'b1;
				wbStb <= 1'b1;
			end
			else if (cycEnd)
			begin
				wbCyc <= 1'b0;
				wbStb <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (mem.start)
		begin
			wbWe <= mem.we;
			wbAdr <= mem.addr;
			wbDatW <= mem.wdata;
		end
		if (cycEnd)
		begin
			mem.rdata <= wbDatR; // only meaningful for reads
		end
	end

	stbInsideCyc: assert property (
		@(posedge clock) disable iff (!arstN)
		wbStb |-> wbCyc
	);

	adrHeldUntilAck: assert property (
		@(posedge clock) disable iff (!arstN)
		wbCyc && !wbAck |=> $stable(wbAdr)
	);

endmodule

/* logic/memReqIf.sv */
`timescale 1ns/1ps

interface memReqIf;

	// start pulses once, done answers once
	logic start;
	logic we;
	logic [31:0] addr;   // physical
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic done;

	modport ctrl (
		output start,
		output we,
		output addr,
		output wdata,
		input  rdata,
		input  done
	);

	modport bridge (
		input  start,
		input  we,
		input  addr,
		input  wdata,
		output rdata,
		output done
	);

endinterface

/* logic/mmuPkg.sv */
package mmuPkg;

	// 4 KiB pages, 32-bit virtual and physical space
	localparam int pageBits = 12;
	localparam int vpnBits = 32 - pageBits;
	localparam int bypassBit = 31; // upper half skips translation
	localparam int numWays = 4;
	localparam int hashShift = 4;

	typedef enum logic [2:0] {
		opNone,
		opLoad,
		opStore,
		opFetch,
		opLdtlb,
		opInvtlb
	} memOpT;

	typedef enum logic [2:0] {
		excNone,
		excTlbMiss,
		excNoRead,
		excNoWrite,
		excNoExec,
		excPrivilege
	} excT;

	// ppn is as wide as vpn
	typedef struct packed {
		logic [vpnBits-1:0] vpn;
		logic [vpnBits-1:0] ppn;
		logic [18:0] reserved;
		logic valid;
		logic readOk;
		logic writeOk;
		logic execOk;
		logic userOk;
	} tlbEntryT;

	// low idxBits of vpn xor (vpn >> 4)
	function automatic logic [vpnBits-1:0] tlbSetHash(logic [vpnBits-1:0] vpn, int idxBits);
		logic [vpnBits-1:0] mask;
		mask = (vpnBits'(1) << idxBits) - vpnBits'(1);
		return (vpn ^ (vpn >> hashShift)) & mask;
	endfunction

endpackage

/* logic/mmuTlb.sv */
`timescale 1ns/1ps

module mmuTlb #(
	parameter int setBits = 6
) (
	input  logic clock,
	input  logic arstN,
	input  logic mmuEnable,
	input  logic userMode,
	input  logic reqValid,
	input  mmuPkg::memOpT reqOp,
	input  logic [31:0] reqAddr,
	input  logic [63:0] reqData,
	output logic reqAck,
	output logic [31:0] rspData,
	output mmuPkg::excT rspExc,
	tlbPortIf.ctrl tlb,
	memReqIf.ctrl mem
);
	import mmuPkg::*;

	typedef enum logic [1:0] {idle, decide, waitMem, ack} stateT;

	stateT state;
	memOpT opReg;
	excT excReg;
	excT chkExc;
	logic [31:0] physAddr;
	logic [31:0] transAddr;
	logic [setBits-1:0] fillSet;
	logic isAccess;

	accessCheck check_i (
		.op(reqOp),
		.entry(tlb.hitEntry),
		.hit(tlb.hit),
		.mmuEnable(mmuEnable),
		.userMode(userMode),
		.addr(reqAddr),
		.exc(chkExc)
	);

	// request fields stay stable until reqAck, so drive straight from them
	assign tlb.lookupVpn = reqAddr[31:pageBits];
	assign tlb.fillEntry = reqData;
	assign transAddr = (mmuEnable && !reqAddr[bypassBit]) ?
		{tlb.hitEntry.ppn, reqAddr[pageBits-1:0]} : reqAddr;
	assign fillSet = setBits'(tlbSetHash(tlb.fillEntry.vpn, setBits));

	assign isAccess = opReg inside {opLoad, opStore, opFetch};
	assign tlb.fillEn = state == decide && opReg == opLdtlb;
	assign tlb.flushAll = state == decide && opReg == opInvtlb;
	assign mem.start = state == decide && isAccess && excReg == excNone;
	assign mem.we = opReg == opStore;
	assign mem.addr = physAddr;
	assign mem.wdata = reqData[31:0];   // store data in the low word
	assign reqAck = state == ack;
	assign rspExc = excReg;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= idle;
			opReg <= opNone;
			excReg <= excNone;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (reqValid)
					begin
						opReg <= reqOp;
						excReg <= chkExc; // lookup result registered here
						state <= decide;
					end
				end
				decide: state <= mem.start ? waitMem : ack;
				waitMem:
				begin
					if (mem.done)
					begin
						state <= ack;
					end
				end
				default: state <= idle; // ack lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == idle && reqValid)
		begin
			physAddr <= transAddr;
		end
		// LDTLB reports which set took the entry
		if (state == decide && !mem.start)
		begin
			rspData <= (opReg == opLdtlb) ? 32'(fillSet) : '0;
		end
		if (state == waitMem && mem.done)
		begin
			rspData <= mem.rdata;
		end
	end

	ackOnePulse: assert property (
		@(posedge clock) disable iff (!arstN)
		reqAck |=> !reqAck
	);

endmodule

/* logic/mmuTop.sv */
`timescale 1ns/1ps

module mmuTop #(
	parameter int setBits = 6
) (
	input  logic clock,
	input  logic arstN,
	input  logic mmuEnable,
	input  logic userMode,
	input  logic reqValid,
	input  mmuPkg::memOpT reqOp,
	input  logic [31:0] reqAddr,
	input  logic [63:0] reqData,
	output logic reqAck,
	output logic [31:0] rspData,
	output mmuPkg::excT rspExc,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [31:0] wbAdr,
	output logic [31:0] wbDatW,
	input  logic [31:0] wbDatR,
	input  logic wbAck
);

	tlbPortIf tlbBus ();
	memReqIf memBus ();

	// request FSM, owns the L1 handshake
	mmuTlb #(
		.setBits(setBits)
	) ctrl_i (
		.clock(clock),
		.arstN(arstN),
		.mmuEnable(mmuEnable),
		.userMode(userMode),
		.reqValid(reqValid),
		.reqOp(reqOp),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.reqAck(reqAck),
		.rspData(rspData),
		.rspExc(rspExc),
		.tlb(tlbBus.ctrl),
		.mem(memBus.ctrl)
	);

	tlbArray #(
		.setBits(setBits)
	) array_i (
		.clock(clock),
		.arstN(arstN),
		.port(tlbBus.array)
	);

	l2WbBridge bridge_i (
		.clock(clock),
		.arstN(arstN),
		.mem(memBus.bridge),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck)
	);

endmodule

/* logic/tlbArray.sv */
`timescale 1ns/1ps

module tlbArray #(
	parameter int setBits = 6
) (
	input  logic clock,
	input  logic arstN,
	tlbPortIf.array port
);
	import mmuPkg::*;

	localparam int numSets = 2 ** setBits;

	tlbEntryT wayMem [numWays][numSets];   // way 0 holds the newest entry
	logic [numSets-1:0] flushMask;         // set bit hides the whole set
	logic [setBits-1:0] lookIdx;
	logic [setBits-1:0] fillIdx;

	assign lookIdx = setBits'(tlbSetHash(port.lookupVpn, setBits));
	assign fillIdx = setBits'(tlbSetHash(port.fillEntry.vpn, setBits));

	// scan from the oldest way so the newest match ends up winning
	always_comb
	begin
		port.hit = 1'b0;
		port.hitEntry = '0;
		for (int w = numWays - 1; w >= 0; w--)
		begin
			if (!flushMask[lookIdx] && wayMem[w][lookIdx].valid &&
				wayMem[w][lookIdx].vpn == port.lookupVpn)
			begin
				port.hit = 1'b1;
				port.hitEntry = wayMem[w][lookIdx];
			end
		end
	end

	// shift-insert fill, oldest way falls off the end
	always_ff @(posedge clock)
	begin
		if (port.fillEn)
		begin
			wayMem[0][fillIdx] <= port.fillEntry;
			for (int w = 1; w < numWays; w++)
			begin
				wayMem[w][fillIdx] <= wayMem[w-1][fillIdx];
				// stale entries of a flushed set must not come back
				if (flushMask[fillIdx])
				begin
					wayMem[w][fillIdx].valid <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			flushMask <= '1; // everything invalid out of reset
		end
		else if (port.flushAll)
		begin
			flushMask <= '1;
		end
		else if (port.fillEn)
		begin
			flushMask[fillIdx] <= 1'b0;
		end
	end

	// controller sequences LDTLB and INVTLB as separate requests
	fillFlushExclusive: assert property (
		@(posedge clock) disable iff (!arstN)
		!(port.fillEn && port.flushAll)
	);

endmodule

/* logic/tlbPortIf.sv */
`timescale 1ns/1ps

interface tlbPortIf;
	import mmuPkg::*;

	logic [vpnBits-1:0] lookupVpn;
	logic fillEn;          // one-cycle pulse
	tlbEntryT fillEntry;
	logic flushAll;        // one-cycle pulse
	logic hit;
	tlbEntryT hitEntry;

	modport ctrl (
		output lookupVpn,
		output fillEn,
		output fillEntry,
		output flushAll,
		input  hit,
		input  hitEntry
	);

	modport array (
		input  lookupVpn,
		input  fillEn,
		input  fillEntry,
		input  flushAll,
		output hit,
		output hitEntry
	);

endinterface

/* run.sh */
#!/bin/sh
# builds the MMU testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tbMmuTop -f files.f -o simMmu

out=$(./obj_dir/simMmu)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'

/* tb/tbMmuTop.sv */
`timescale 1ns/1ps

module tbMmuTop;
	import mmuPkg::*;

	localparam int setBits = 6;
	localparam int ackTimeout = 40; // cycles

	logic clock;
	logic arstN;
	logic mmuEnable;
	logic userMode;
	logic reqValid;
	memOpT reqOp;
	logic [31:0] reqAddr;
	logic [63:0] reqData;
	logic reqAck;
	logic [31:0] rspData;
	excT rspExc;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [31:0] wbAdr;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic wbAck;
	logic [1:0] ackDelay;
	int accessCount;

	// expectations for the request in flight
	string testName;
	excT expExc;
	logic expectWb;
	logic expWe;
	logic [31:0] expWbAdr;
	logic [31:0] expWdat;
	logic checkData;
	logic [31:0] expData;

	int errors;
	int timeouts;
	int expAccesses;
	logic hung;
	logic [31:0] lfsrState;
	tlbEntryT refTlb [4][2**setBits];      // reference TLB with way 0 newest
	logic [31:0] written [logic [31:0]];   // stored words by physical address

	mmuTop #(.setBits(setBits)) dut_i (.*);
	tbWbSlave slave_i (.*);

	always #5 clock = ~clock;

	excAtAck: assert property (@(posedge clock) disable iff (!arstN) reqAck |-> rspExc == expExc)
	else
	begin
		errors++;
		$display("[FAIL] %s rspExc expected %s actual %s", testName, expExc.name(), rspExc.name());
	end

	dataAtAck: assert property (@(posedge clock) disable iff (!arstN)
		reqAck && checkData |-> rspData == expData)
	else
	begin
		errors++;
		$display("[FAIL] %s rspData expected %h actual %h", testName, expData, rspData);
	end

	adrAtWbAck: assert property (@(posedge clock) disable iff (!arstN)
		wbCyc && wbAck |-> wbAdr == expWbAdr && wbWe == expWe)
	else
	begin
		errors++;
		$display("[FAIL] %s wbAdr/wbWe expected %h/%b actual %h/%b",
			testName, expWbAdr, expWe, wbAdr, wbWe);
	end

	datAtWbAck: assert property (@(posedge clock) disable iff (!arstN)
		wbCyc && wbAck && wbWe |-> wbDatW == expWdat)
	else
	begin
		errors++;
		$display("[FAIL] %s wbDatW expected %h actual %h", testName, expWdat, wbDatW);
	end

	noStrayCycle: assert property (@(posedge clock) disable iff (!arstN) wbCyc |-> expectWb)
	else
	begin
		errors++;
		$display("unexpected Wishbone cycle during test %s", testName);
	end

	// classic cycle keeps stb and cyc together
	stbWithCyc: assert property (@(posedge clock) disable iff (!arstN) wbStb == wbCyc)
	else
	begin
		errors++;
		$display("wbStb and wbCyc differ during test %s", testName);
	end

	// faults and TLB maintenance answer in a fixed two cycles
	fixedLatency: assert property (@(posedge clock) disable iff (!arstN)
		$rose(reqValid) && !expectWb |-> ##2 reqAck)
	else
	begin
		errors++;
		$display("reqAck missing two cycles after the request in test %s", testName);
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] randBits(int n);
		logic [31:0] value;
		logic lsb;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lsb = lfsrState[0];
			lfsrState = (lfsrState >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);
			value = {value[30:0], lsb};
		end
		return value;
	endfunction

	function automatic int setIndex(logic [19:0] vpn);
		logic [setBits-1:0] low;
		logic [setBits-1:0] high;
		low = vpn[setBits-1:0];
		high = vpn[setBits+3:4];
		return int'(low ^ high);
	endfunction

	function automatic int refWay(logic [19:0] vpn);
		int idx;
		idx = setIndex(vpn);
		for (int w = 0; w < 4; w++)
			if (refTlb[w][idx].valid && refTlb[w][idx].vpn == vpn)
				return w;
		return -1;
	endfunction

	function automatic excT refExc(memOpT op, logic [31:0] addr);
		int way;
		tlbEntryT e;
		if (!(op inside {opLoad, opStore, opFetch}) || !mmuEnable)
			return excNone;
		if (addr[31])
			return userMode ? excPrivilege : excNone;
		way = refWay(addr[31:12]);
		if (way < 0)
			return excTlbMiss;
		e = refTlb[way][setIndex(addr[31:12])];
		if (userMode && !e.userOk)
			return excPrivilege;
		if (op == opLoad && !e.readOk)
			return excNoRead;
		if (op == opStore && !e.writeOk)
			return excNoWrite;
		if (op == opFetch && !e.execOk)
			return excNoExec;
		return excNone;
	endfunction

	function automatic tlbEntryT makeEntry(logic [19:0] vpn, logic [19:0] ppn, logic [3:0] rwxu);
		tlbEntryT e;
		e = '0;
		e.vpn = vpn;
		e.ppn = ppn;
		e.valid = 1'b1;
		e.readOk = rwxu[3];
		e.writeOk = rwxu[2];
		e.execOk = rwxu[1];
		e.userOk = rwxu[0];
		return e;
	endfunction

	// one request from raising reqValid to the idle cycle after reqAck
	task automatic runRequest(input string name, input memOpT op, input logic [31:0] addr,
		input logic [63:0] data);
		int way;
		int idx;
		int cycles;
		excT exc;
		logic [31:0] pa;
		tlbEntryT e;
		if (hung)
			return;
		@(posedge clock);
		#1;
		exc = refExc(op, addr);
		way = refWay(addr[31:12]);
		pa = addr;
		if (mmuEnable && !addr[31] && way >= 0)
			pa = {refTlb[way][setIndex(addr[31:12])].ppn, addr[11:0]};
		testName = name;
		expExc = exc;
		expectWb = op inside {opLoad, opStore, opFetch} && exc == excNone;
		expWe = op == opStore;
		expWbAdr = pa;
		expWdat = data[31:0];
		checkData = op == opLoad && expectWb && written.exists(pa);
		expData = checkData ? written[pa] : '0;
		ackDelay = 2'(randBits(2));
		reqOp = op;
		reqAddr = addr;
		reqData = data;
		reqValid = 1'b1;
		cycles = 0;
		while (!reqAck && cycles < ackTimeout)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!reqAck)
		begin
			timeouts++;
			hung = 1'b1;
			$display("no reqAck within %0d cycles in test %s", ackTimeout, name);
			return;
		end
		@(posedge clock);
		#1;
		reqValid = 1'b0;
		if (expectWb)
			expAccesses++;
		if (op == opStore && expectWb)
			written[pa] = data[31:0];
		if (op == opLdtlb)
		begin
			e = data;
			idx = setIndex(e.vpn);
			for (int w = 3; w > 0; w--)
				refTlb[w][idx] = refTlb[w-1][idx];
			refTlb[0][idx] = e;
		end
		if (op == opInvtlb)
			foreach (refTlb[w, s])
				refTlb[w][s].valid = 1'b0;
		expectWb = 1'b0;
		checkData = 1'b0;
	endtask

	initial
	begin
		logic [31:0] addrA;
		logic [31:0] dataA;
		logic [19:0] pageA;
		logic [19:0] pageB;
		logic [19:0] pageC;
		logic [19:0] ppnA;
		logic [11:0] offA;
		clock = 1'b0;
		arstN = 1'b0;
		mmuEnable = 1'b0;
		userMode = 1'b0;
		reqValid = 1'b0;
		reqOp = opNone;
		reqAddr = '0;
		reqData = '0;
		ackDelay = '0;
		testName = "reset";
		expExc = excNone;
		expectWb = 1'b0;
		expWe = 1'b0;
		expWbAdr = '0;
		expWdat = '0;
		checkData = 1'b0;
		expData = '0;
		errors = 0;
		timeouts = 0;
		expAccesses = 0;
		hung = 1'b0;
		lfsrState = 32'd93915;
		foreach (refTlb[w, s])
			refTlb[w][s] = '0;
		repeat (4) @(posedge clock);
		#1 arstN = 1'b1;

		// MMU off so addresses go out untouched
		for (int i = 0; i < 3; i++)
		begin
			addrA = randBits(32);
			dataA = randBits(32);
			runRequest("identity store", opStore, addrA, {32'h0, dataA});
			runRequest("identity load", opLoad, addrA, '0);
		end

		mmuEnable = 1'b1;
		pageA = {1'b0, 19'(randBits(19))};
		pageB = pageA ^ 20'h1_0000;
		pageC = {1'b0, 19'(randBits(19))};
		ppnA = 20'(randBits(20));
		offA = 12'(randBits(12));
		dataA = randBits(32);
		runRequest("miss on empty TLB", opLoad, {pageA, offA}, '0);

		runRequest("ldtlb full rights", opLdtlb, '0, makeEntry(pageA, ppnA, 4'b1111));
		runRequest("translated store", opStore, {pageA, offA}, {32'h0, dataA});
		runRequest("translated load", opLoad, {pageA, offA}, '0);
		runRequest("translated fetch", opFetch, {pageA, 12'(randBits(12))}, '0);
		runRequest("supervisor bypass", opLoad, {1'b1, 31'(randBits(31))}, '0);

		// read-only supervisor page
		runRequest("ldtlb read only", opLdtlb, '0, makeEntry(pageB, 20'(randBits(20)), 4'b1000));
		runRequest("store without writeOk", opStore, {pageB, 12'(randBits(12))}, 64'(randBits(32)));
		runRequest("fetch without execOk", opFetch, {pageB, 12'(randBits(12))}, '0);
		runRequest("supervisor read", opLoad, {pageB, 12'(randBits(12))}, '0);
		userMode = 1'b1;
		runRequest("user without userOk", opLoad, {pageB, 12'(randBits(12))}, '0);
		runRequest("user bypass", opLoad, {1'b1, 31'(randBits(31))}, '0);
		runRequest("user with userOk", opLoad, {pageA, offA}, '0);
		userMode = 1'b0;

		// bits 12 and up leave the set index alone
		for (int k = 0; k < 5; k++)
			runRequest("ldtlb same set", opLdtlb, '0,
				makeEntry(pageC ^ (20'(k + 1) << 12), 20'(randBits(20)), 4'b1111));
		for (int k = 0; k < 5; k++)
			runRequest(k == 0 ? "oldest way dropped" : "newer ways hit", opLoad,
				{pageC ^ (20'(k + 1) << 12), 12'(randBits(12))}, '0);

		runRequest("invtlb", opInvtlb, '0, '0);
		runRequest("flushed page A", opLoad, {pageA, offA}, '0);
		runRequest("flushed page B", opLoad, {pageB, 12'(randBits(12))}, '0);
		runRequest("flushed page C", opLoad, {pageC ^ 20'h0_5000, 12'(randBits(12))}, '0);
		runRequest("ldtlb after flush", opLdtlb, '0, makeEntry(pageA, ppnA, 4'b1111));
		runRequest("hit after refill", opLoad, {pageA, offA}, '0);

		@(posedge clock);
		#1;
		if (accessCount != expAccesses)
		begin
			errors++;
			$display("[FAIL] wishbone access count expected %0d actual %0d",
				expAccesses, accessCount);
		end
		$display("failed checks: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* tb/tbWbSlave.sv */
`timescale 1ns/1ps

module tbWbSlave (
	input  logic clock,
	input  logic arstN,
	input  logic wbCyc,
	input  logic wbStb,
	input  logic wbWe,
	input  logic [31:0] wbAdr,
	input  logic [31:0] wbDatW,
	output logic [31:0] wbDatR,
	output logic wbAck,
	input  logic [1:0] ackDelay,   // extra wait cycles, taken when a cycle opens
	output int accessCount         // completed accesses so far
);

	logic [31:0] memData [logic [31:0]];
	logic busy;
	logic [1:0] waitLeft;

	// untouched words read back as a mix of their own address
	function automatic logic [31:0] fillWord(logic [31:0] adr);
		return {adr[15:0], adr[31:16]} ^ 32'h6B3D_91C5;
	endfunction

	always @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			wbAck <= 1'b0;
			wbDatR <= '0;
			busy <= 1'b0;
			waitLeft <= '0;
			accessCount <= 0;
		end
		else if (wbAck)
		begin
			wbAck <= 1'b0; // master drops cyc on this same edge
			busy <= 1'b0;
		end
		else if (wbCyc && wbStb)
		begin
			if (!busy)
			begin
				busy <= 1'b1;
				waitLeft <= ackDelay;
			end
			else if (waitLeft != 2'd0)
				waitLeft <= waitLeft - 2'd1;
			else
			begin
				wbAck <= 1'b1;
				accessCount <= accessCount + 1;
				if (wbWe)
					memData[wbAdr] = wbDatW;
				else
					wbDatR <= memData.exists(wbAdr) ? memData[wbAdr] : fillWord(wbAdr);
			end
		end
	end

endmodule
